// ==== design/dcache_pkg.sv ====
package dcache_pkg;

    //////////////////////////////
    // cache geometry
    //////////////////////////////

    localparam int OFFSET_W = 2;    // byte offset inside the one-word line
    localparam int INDEX_W  = 4;    // address bits 5..2
    localparam int SETS     = 16;
    localparam int WAYS     = 2;    // hit select and victim pick are 2-way only
    localparam int TAG_W    = 32 - INDEX_W - OFFSET_W;

    //////////////////////////////
    // types
    //////////////////////////////

    typedef logic [31:0]        addr_t;     // byte address
    typedef logic [31:0]        word_t;
    typedef logic [3:0]         strb_t;     // one bit per byte
    typedef logic [TAG_W-1:0]   tag_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [WAYS-1:0]    way_t;      // one-hot way vector
    typedef logic [31:0]        count_t;

    // main controller
    typedef enum logic [2:0] {
        idle,
        lookup,
        write_wait,     // write sent and not yet taken by memory
        read_wait,      // miss or uncached read outstanding
        refill          // one cycle to write the fetched word
    } ctrl_state_t;

endpackage

// ==== design/dcache_if.sv ====
// buffered request shared by request buffer, controller and store
interface req_if;
    import dcache_pkg::*;

    addr_t addr;
    word_t wdata;
    strb_t wstrb;
    logic  is_write;
    logic  uncached;
    logic  load;        // capture the next pipeline request

    modport buffer (
        output addr, wdata, wstrb, is_write, uncached,
        input  load
    );

    modport ctrl (
        input  is_write, uncached,
        output load
    );

    // store takes the address for compare and data and strobe for the merge
    modport store (
        input addr, wdata, wstrb
    );
endinterface

// array control and lookup results between controller and store
interface array_if;
    import dcache_pkg::*;

    way_t  hit;
    word_t hit_rdata;
    way_t  victim;          // LRU way of the current set
    way_t  data_we;         // writes tag, valid and data together
    logic  wstrb_merge;     // 1 on hit write, 0 on refill
    word_t refill_data;
    way_t  invalidate;
    way_t  use_way;         // LRU update

    modport ctrl (
        input  hit, hit_rdata, victim,
        output data_we, wstrb_merge, refill_data, invalidate, use_way
    );

    modport store (
        output hit, hit_rdata, victim,
        input  data_we, wstrb_merge, refill_data, invalidate, use_way
    );
endinterface

// ==== design/dcache_req_buf.sv ====
module dcache_req_buf (
    input  logic              clk,
    input  logic              rstn,
    input  logic              req_valid,
    input  dcache_pkg::addr_t req_addr,
    input  dcache_pkg::word_t req_wdata,
    input  dcache_pkg::strb_t req_wstrb,
    input  logic              req_write,
    input  logic              req_uncached,
    req_if.buffer             rq
);

    logic take;     // request accepted this edge

    assign take = rq.load && req_valid;

    // request kind
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rq.is_write <= 1'b0;
            rq.uncached <= 1'b0;
        end else if (take) begin
            rq.is_write <= req_write;
            rq.uncached <= req_uncached;
        end
    end

    //////////////////////////////
    // payload
    //////////////////////////////

    // address also feeds mem_addr until the next load
    always_ff @(posedge clk) begin
        if (take) begin
            rq.addr  <= req_addr;
            rq.wdata <= req_wdata;
            rq.wstrb <= req_wstrb;
        end
    end

endmodule

// ==== design/dcache_ctrl.sv ====
module dcache_ctrl (
    input  logic               clk,
    input  logic               rstn,
    input  logic               req_valid,
    output logic               req_ready,
    req_if.ctrl                rq,
    array_if.ctrl              ar,
    output logic               mem_req,
    output logic               mem_wr,
    input  logic               mem_addr_ok,
    input  logic               mem_data_ok,
    input  dcache_pkg::word_t  mem_rdata,
    output logic               resp_valid,
    output dcache_pkg::word_t  resp_rdata,
    output dcache_pkg::count_t hit_count,
    output dcache_pkg::count_t miss_count
);
    import dcache_pkg::*;

    ctrl_state_t state;
    ctrl_state_t next_state;
    ctrl_state_t accept_next;   // where to go once ready is given
    way_t        hit_sel;       // one hit way with way 0 first
    logic        miss;
    logic        hit_inc;
    logic        miss_inc;
    word_t       refill_q;

    assign miss        = ~|ar.hit || rq.uncached;
    assign hit_sel     = ar.hit[0] ? 2'b01 : (ar.hit[1] ? 2'b10 : 2'b00);
    assign accept_next = req_valid ? lookup : idle;

    assign rq.load        = req_ready;  // buffer loads whenever ready is high
    assign ar.refill_data = refill_q;

    always_ff @(posedge clk) begin
        if (!rstn)
            state <= idle;
        else
            state <= next_state;
    end

    // memory word for the refill cycle
    always_ff @(posedge clk) begin
        if (mem_data_ok)
            refill_q <= mem_rdata;
    end

    //////////////////////////////
    // main FSM
    //////////////////////////////

    always_comb begin
        next_state     = state;
        req_ready      = 1'b0;
        mem_req        = 1'b0;
        mem_wr         = 1'b0;
        resp_valid     = 1'b0;
        resp_rdata     = ar.hit_rdata;
        ar.data_we     = '0;
        ar.wstrb_merge = 1'b0;
        ar.invalidate  = '0;
        ar.use_way     = '0;
        hit_inc        = 1'b0;
        miss_inc       = 1'b0;

        case (state)
            idle: begin
                req_ready = 1'b1;
                if (req_valid)
                    next_state = lookup;
            end

            lookup: begin
                hit_inc  = ~miss;
                miss_inc = miss;
                if (rq.uncached)
                    ar.invalidate = hit_sel;    // drop any cached copy
                if (rq.is_write) begin
                    mem_req = 1'b1;             // write-through on hit and miss
                    mem_wr  = 1'b1;
                    if (!miss) begin
                        ar.data_we     = hit_sel;
                        ar.wstrb_merge = 1'b1;
                        ar.use_way     = hit_sel;
                    end
                    if (mem_addr_ok) begin
                        req_ready  = 1'b1;
                        next_state = accept_next;
                    end else begin
                        next_state = write_wait;
                    end
                end else if (!miss) begin
                    resp_valid = 1'b1;          // read hit
                    ar.use_way = hit_sel;
                    req_ready  = 1'b1;
                    next_state = accept_next;
                end else begin
                    mem_req = 1'b1;
                    if (mem_data_ok) begin      // zero-delay memory
                        resp_valid = 1'b1;
                        resp_rdata = mem_rdata;
                        next_state = refill;
                    end else begin
                        next_state = read_wait;
                    end
                end
            end

            write_wait: begin
                mem_req = 1'b1;
                mem_wr  = 1'b1;
                if (mem_addr_ok) begin
                    req_ready  = 1'b1;
                    next_state = accept_next;
                end
            end

            read_wait: begin
                mem_req = 1'b1;
                if (mem_data_ok) begin
                    resp_valid = 1'b1;
                    resp_rdata = mem_rdata;
                    next_state = refill;
                end
            end

            refill: begin
                req_ready = 1'b1;
                if (!rq.uncached) begin         // uncached reads leave the arrays alone
                    ar.data_we = ar.victim;
                    ar.use_way = ar.victim;
                end
                next_state = accept_next;
            end

            default: next_state = idle;
        endcase
    end

    // event counters
    always_ff @(posedge clk) begin
        if (!rstn) begin
            hit_count  <= '0;
            miss_count <= '0;
        end else begin
            if (hit_inc)
                hit_count <= hit_count + 1'b1;
            if (miss_inc)
                miss_count <= miss_count + 1'b1;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    assert property (@(posedge clk) disable iff (!rstn) mem_wr |-> mem_req)
        else $error("mem_wr without mem_req in %s", state.name());

    // a write not yet taken must stay on the port
    assert property (@(posedge clk) disable iff (!rstn)
        mem_req && mem_wr && !mem_addr_ok |=> mem_req && mem_wr)
        else $error("memory write dropped before mem_addr_ok");

    assert property (@(posedge clk) disable iff (!rstn)
        $onehot0(ar.data_we) && $onehot0(ar.invalidate))
        else $error("more than one way strobed in %s", state.name());

    assert property (@(posedge clk) disable iff (!rstn) state == idle |-> !resp_valid)
        else $error("resp_valid while idle");

endmodule

// ==== design/dcache_store.sv ====
module dcache_store (
    input  logic  clk,
    input  logic  rstn,
    req_if.store  rq,
    array_if.store ar
);
    import dcache_pkg::*;

    tag_t               tag_mem  [WAYS][SETS];
    word_t              data_mem [WAYS][SETS];
    way_t               valid_q  [SETS];    // both ways' valid bits per set
    logic [SETS-1:0]    lru_q;              // 0 means way 0 is least recent

    index_t idx;
    tag_t   tag;
    way_t   hit_w;
    word_t  wr_word;

    assign idx = rq.addr[OFFSET_W +: INDEX_W];
    assign tag = rq.addr[OFFSET_W + INDEX_W +: TAG_W];

    //////////////////////////////
    // lookup
    //////////////////////////////

    always_comb begin
        for (int w = 0; w < WAYS; w++)
            hit_w[w] = valid_q[idx][w] && (tag_mem[w][idx] == tag);
    end

    assign ar.hit       = hit_w;
    assign ar.hit_rdata = hit_w[1] ? data_mem[1][idx] : data_mem[0][idx];
    assign ar.victim    = lru_q[idx] ? 2'b10 : 2'b01;

    // merge uses the hit word, since only the hit way takes a merged write
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            if (!ar.wstrb_merge)
                wr_word[8*b +: 8] = ar.refill_data[8*b +: 8];
            else if (rq.wstrb[b])
                wr_word[8*b +: 8] = rq.wdata[8*b +: 8];
            else
                wr_word[8*b +: 8] = ar.hit_rdata[8*b +: 8];
        end
    end

    //////////////////////////////
    // arrays
    //////////////////////////////

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAYS; w++) begin
            if (ar.data_we[w]) begin
                tag_mem[w][idx]  <= tag;
                data_mem[w][idx] <= wr_word;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < SETS; s++)
                valid_q[s] <= '0;
            lru_q <= '0;
        end else begin
            for (int w = 0; w < WAYS; w++) begin
                if (ar.data_we[w])
                    valid_q[idx][w] <= 1'b1;
                else if (ar.invalidate[w])
                    valid_q[idx][w] <= 1'b0;
            end
            // point at the way not just used
            if (ar.use_way[0])
                lru_q[idx] <= 1'b1;
            else if (ar.use_way[1])
                lru_q[idx] <= 1'b0;
        end
    end

    // controller must never fill and drop the same way at once
    assert property (@(posedge clk) disable iff (!rstn) !(|(ar.data_we & ar.invalidate)))
        else $error("data_we and invalidate on the same way, set %0d", idx);

endmodule

// ==== design/dcache_top.sv ====
module dcache_top (
    input  logic               clk,
    input  logic               rstn,
    // pipeline side
    input  logic               req_valid,
    output logic               req_ready,
    input  dcache_pkg::addr_t  req_addr,
    input  logic               req_write,
    input  dcache_pkg::strb_t  req_wstrb,
    input  dcache_pkg::word_t  req_wdata,
    input  logic               req_uncached,
    output logic               resp_valid,
    output dcache_pkg::word_t  resp_rdata,
    output dcache_pkg::count_t hit_count,
    output dcache_pkg::count_t miss_count,
    // memory side
    output logic               mem_req,
    output logic               mem_wr,
    output dcache_pkg::addr_t  mem_addr,
    output dcache_pkg::word_t  mem_wdata,
    output dcache_pkg::strb_t  mem_wstrb,
    input  dcache_pkg::word_t  mem_rdata,
    input  logic               mem_addr_ok,
    input  logic               mem_data_ok
);

    req_if   rq_bus ();
    array_if ar_bus ();

    // memory port takes the buffered request as is
    assign mem_addr  = rq_bus.addr;
    assign mem_wdata = rq_bus.wdata;
    assign mem_wstrb = rq_bus.wstrb;

    dcache_req_buf u_req_buf (
        .clk(clk), .rstn(rstn), .req_valid(req_valid),
        .req_addr(req_addr), .req_wdata(req_wdata), .req_wstrb(req_wstrb),
        .req_write(req_write), .req_uncached(req_uncached),
        .rq(rq_bus)
    );

    dcache_ctrl u_ctrl (
        .clk(clk), .rstn(rstn), .req_valid(req_valid), .req_ready(req_ready),
        .rq(rq_bus), .ar(ar_bus),
        .mem_req(mem_req), .mem_wr(mem_wr), .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok), .mem_rdata(mem_rdata),
        .resp_valid(resp_valid), .resp_rdata(resp_rdata),
        .hit_count(hit_count), .miss_count(miss_count)
    );

    dcache_store u_store (
        .clk(clk), .rstn(rstn), .rq(rq_bus), .ar(ar_bus)
    );

endmodule

// ==== test/dcache_checker.sv ====
module dcache_checker (
    input  logic               clk,
    input  logic               rstn,
    input  logic               req_valid,
    input  logic               req_ready,
    input  logic               resp_valid,
    input  dcache_pkg::word_t  resp_rdata,
    input  dcache_pkg::count_t hit_count,
    input  dcache_pkg::count_t miss_count,
    // expected values driven alongside each request
    input  logic [127:0]       exp_name,
    input  logic               exp_write,
    input  dcache_pkg::word_t  exp_rdata,
    input  logic               exp_hit,
    input  logic               end_req,
    output int                 pass_n,
    output int                 fail_n,
    output logic               final_done
);
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    localparam int MAX_T = 32;

    // one slot per accepted request in issue order
    logic [127:0] name_q   [MAX_T];
    logic         wr_q     [MAX_T];
    word_t        rd_q     [MAX_T];
    logic         hit_q    [MAX_T];
    logic         got_resp [MAX_T];
    word_t        got_rd   [MAX_T];
    logic         got_hit  [MAX_T];

    int     acc_n, done_n, cnt_n, rep_n;
    int     exp_hits, exp_misses;
    count_t hc_prev, mc_prev;

    task automatic report_test(input int k);
        logic bad;
        bad = 1'b0;
        if (got_hit[k] !== hit_q[k]) begin
            $display("** Error: test %0s hit expected %0b, actual %0b",
                     name_q[k], hit_q[k], got_hit[k]);
            bad = 1'b1;
        end
        if (wr_q[k] && got_resp[k]) begin
            $display("test %0s: write returned a read response", name_q[k]);
            bad = 1'b1;
        end else if (!wr_q[k] && !got_resp[k]) begin
            $display("test %0s: ready came back with no read response", name_q[k]);
            bad = 1'b1;
        end else if (!wr_q[k] && got_rd[k] !== rd_q[k]) begin
            $display("** Error: test %0s rdata expected %h, actual %h",
                     name_q[k], rd_q[k], got_rd[k]);
            bad = 1'b1;
        end
        if (bad)
            fail_n++;
        else begin
            pass_n++;
            $display("test %0s ok", name_q[k]);
        end
    endtask

    task automatic check_totals();
        if (hit_count !== count_t'(exp_hits) || miss_count !== count_t'(exp_misses)) begin
            $display("** Error: test counters expected %0d/%0d, actual %0d/%0d (hit/miss)",
                     exp_hits, exp_misses, hit_count, miss_count);
            fail_n++;
        end else begin
            pass_n++;
            $display("test counters ok");
        end
        $display("tests passed %0d, failed %0d", pass_n, fail_n);
    endtask

    //////////////////////////////
    // sampled mid-cycle when all inputs have settled
    //////////////////////////////

    always @(negedge clk) begin
        if (!rstn) begin
            acc_n      = 0;
            done_n     = 0;
            cnt_n      = 0;
            rep_n      = 0;
            exp_hits   = 0;
            exp_misses = 0;
            pass_n     = 0;
            fail_n     = 0;
            final_done = 1'b0;
            hc_prev    = '0;
            mc_prev    = '0;
        end else begin
            // each lookup steps one counter in issue order
            if (hit_count != hc_prev || miss_count != mc_prev) begin
                got_hit[cnt_n] = (hit_count != hc_prev);
                cnt_n++;
            end
            hc_prev = hit_count;
            mc_prev = miss_count;

            if (done_n < acc_n) begin
                if (resp_valid) begin
                    got_resp[done_n] = 1'b1;
                    got_rd[done_n]   = resp_rdata;
                end
                if (req_ready)              // ready again ends the request
                    done_n++;
            end else if (resp_valid) begin
                $display("response seen with no request outstanding");
                fail_n++;
            end

            if (req_valid && req_ready) begin
                name_q[acc_n]   = exp_name;
                wr_q[acc_n]     = exp_write;
                rd_q[acc_n]     = exp_rdata;
                hit_q[acc_n]    = exp_hit;
                got_resp[acc_n] = 1'b0;
                if (exp_hit)
                    exp_hits++;
                else
                    exp_misses++;
                acc_n++;
            end

            while (rep_n < done_n && rep_n < cnt_n) begin
                report_test(rep_n);
                rep_n++;
            end

            if (end_req && !final_done && rep_n == acc_n) begin
                check_totals();
                final_done = 1'b1;
            end
        end
    end

endmodule

// ==== test/tb_top.sv ====
module tb_top;
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_pkg::*;

    localparam int    MEM_WORDS = 1024;         // 4 KiB indexed by addr[11:2]
    localparam word_t PATTERN   = 32'h5eed_c0de;
    localparam int    TIMEOUT   = 200;          // cycles per wait
    localparam int    SEED      = 50;
    localparam int    MAX_ROWS  = 32;
    localparam logic  RD        = 1'b0;
    localparam logic  WR        = 1'b1;

    logic         clk, rstn;
    logic         req_valid, req_ready, req_write, req_uncached;
    addr_t        req_addr, mem_addr;
    strb_t        req_wstrb, mem_wstrb;
    word_t        req_wdata, resp_rdata, mem_wdata, mem_rdata;
    logic         resp_valid, mem_req, mem_wr, mem_addr_ok, mem_data_ok;
    count_t       hit_count, miss_count;
    logic [127:0] exp_name;
    logic         exp_write, exp_hit, end_req, final_done, run_ok;
    word_t        exp_rdata;
    int           pass_n, fail_n, n_rows, delay_left;

    // stimulus table
    logic [127:0] t_name  [MAX_ROWS];
    logic         t_wr    [MAX_ROWS];
    addr_t        t_addr  [MAX_ROWS];
    word_t        t_wdata [MAX_ROWS];
    strb_t        t_strb  [MAX_ROWS];
    logic         t_unc   [MAX_ROWS];
    word_t        t_rdata [MAX_ROWS];
    logic         t_hit   [MAX_ROWS];
    word_t        mem     [MEM_WORDS];

    dcache_top dut0 (.*);

    dcache_checker checker0 (.*);

    function automatic word_t pattern_word(addr_t a);
        return a ^ PATTERN;
    endfunction

    function automatic word_t merge_bytes(word_t old_w, word_t new_w, strb_t s);
        word_t r;
        for (int b = 0; b < 4; b++)
            r[8*b +: 8] = s[b] ? new_w[8*b +: 8] : old_w[8*b +: 8];
        return r;
    endfunction

    task automatic add_row(input logic [127:0] name, input logic wr, input addr_t a,
                           input word_t wd, input strb_t s, input logic unc,
                           input word_t rd, input logic hit);
        t_name[n_rows]  = name;
        t_wr[n_rows]    = wr;
        t_addr[n_rows]  = a;
        t_wdata[n_rows] = wd;
        t_strb[n_rows]  = s;
        t_unc[n_rows]   = unc;
        t_rdata[n_rows] = rd;
        t_hit[n_rows]   = hit;
        n_rows++;
    endtask

    //////////////////////////////
    // name op addr wdata strb unc rdata hit
    //////////////////////////////

    task automatic fill_table();
        word_t m100;
        m100   = merge_bytes(pattern_word(32'h100), 32'haabbccdd, 4'b0101);
        n_rows = 0;
        add_row("rd_miss",       RD, 32'h100, 0, 4'h0, 0, pattern_word(32'h100), 0);
        add_row("rd_hit",        RD, 32'h100, 0, 4'h0, 0, pattern_word(32'h100), 1);
        add_row("wr_hit",        WR, 32'h100, 32'haabbccdd, 4'b0101, 0, 0, 1);
        add_row("rd_merged",     RD, 32'h100, 0, 4'h0, 0, m100, 1);
        add_row("unc_rd",        RD, 32'h100, 0, 4'h0, 1, m100, 0);    // memory copy
        add_row("rd_after_unc",  RD, 32'h100, 0, 4'h0, 0, m100, 0);
        add_row("wr_miss",       WR, 32'h204, 32'h11223344, 4'hf, 0, 0, 0);
        add_row("rd_no_alloc",   RD, 32'h204, 0, 4'h0, 0, 32'h11223344, 0);
        // three tags in set 2
        add_row("set_a",         RD, 32'h008, 0, 4'h0, 0, pattern_word(32'h008), 0);
        add_row("set_b",         RD, 32'h408, 0, 4'h0, 0, pattern_word(32'h408), 0);
        add_row("set_a_hit",     RD, 32'h008, 0, 4'h0, 0, pattern_word(32'h008), 1);
        add_row("set_c",         RD, 32'h808, 0, 4'h0, 0, pattern_word(32'h808), 0);
        add_row("set_a_kept",    RD, 32'h008, 0, 4'h0, 0, pattern_word(32'h008), 1);
        add_row("set_b_evicted", RD, 32'h408, 0, 4'h0, 0, pattern_word(32'h408), 0);
        add_row("b2b_wr_a",      WR, 32'h008, 32'hdeadbeef, 4'hf, 0, 0, 1);
        add_row("b2b_rd_a",      RD, 32'h008, 0, 4'h0, 0, 32'hdeadbeef, 1);
        add_row("b2b_rd_b",      RD, 32'h408, 0, 4'h0, 0, pattern_word(32'h408), 1);
        add_row("b2b_rd_m",      RD, 32'h204, 0, 4'h0, 0, 32'h11223344, 1);
        add_row("b2b_wr_unc",    WR, 32'h204, 32'h55667788, 4'b0011, 1, 0, 0);
        add_row("b2b_rd_unc",    RD, 32'h204, 0, 4'h0, 0,
                merge_bytes(32'h11223344, 32'h55667788, 4'b0011), 0);
    endtask

    task automatic wait_accept(input int i, output logic ok);
        int n;
        n = 0;
        @(negedge clk);
        while (!req_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        ok = req_ready;
        if (!ok)
            $display("timeout: test %0s was never accepted", t_name[i]);
        @(posedge clk);
        #1;
    endtask

    task automatic wait_final(output logic ok);
        int n;
        n = 0;
        while (!final_done && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        ok = final_done;
        if (!ok)
            $display("timeout: not every request finished");
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // memory model answering after 0 to 5 cycles
    initial begin
        void'($urandom(SEED));
        for (int i = 0; i < MEM_WORDS; i++)
            mem[i] = pattern_word(addr_t'(i) << 2);
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata   = '0;
        delay_left  = -1;
        forever begin
            @(posedge clk);
            #1;
            mem_addr_ok = 1'b0;
            mem_data_ok = 1'b0;
            if (!rstn || !mem_req) begin
                delay_left = -1;
            end else begin
                if (delay_left < 0)
                    delay_left = $urandom_range(5, 0);
                if (delay_left == 0) begin
                    if (mem_wr) begin
                        mem[mem_addr[11:2]] = merge_bytes(mem[mem_addr[11:2]], mem_wdata,
                                                          mem_wstrb);
                        mem_addr_ok = 1'b1;
                    end else begin
                        mem_rdata   = mem[mem_addr[11:2]];
                        mem_data_ok = 1'b1;
                    end
                end
                delay_left--;
            end
        end
    end

    initial begin
        rstn         = 1'b0;
        req_valid    = 1'b0;
        req_write    = 1'b0;
        req_uncached = 1'b0;
        req_addr     = '0;
        req_wstrb    = '0;
        req_wdata    = '0;
        exp_name     = '0;
        exp_write    = 1'b0;
        exp_rdata    = '0;
        exp_hit      = 1'b0;
        end_req      = 1'b0;
        run_ok       = 1'b1;
        fill_table();
        repeat (16) @(posedge clk);
        #1;
        rstn = 1'b1;

        for (int i = 0; i < n_rows; i++) begin
            if (run_ok) begin
                req_valid    = 1'b1;
                req_write    = t_wr[i];
                req_addr     = t_addr[i];
                req_wdata    = t_wdata[i];
                req_wstrb    = t_strb[i];
                req_uncached = t_unc[i];
                exp_name     = t_name[i];
                exp_write    = t_wr[i];
                exp_rdata    = t_rdata[i];
                exp_hit      = t_hit[i];
                wait_accept(i, run_ok);
            end
        end
        req_valid = 1'b0;
        end_req   = 1'b1;
        if (run_ok)
            wait_final(run_ok);

        if (run_ok && fail_n == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

// ==== tb.f ====
design/dcache_pkg.sv
design/dcache_if.sv
design/dcache_req_buf.sv
design/dcache_ctrl.sv
design/dcache_store.sv
design/dcache_top.sv
test/dcache_checker.sv
test/tb_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0
FAIL_MSG  := Simulation FAILED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), search $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
